/* common/tmr_params.svh */
`ifndef TMR_PARAMS_SVH
`define TMR_PARAMS_SVH

// width of one replica word.
`define TMR_WIDTH 8

// wishbone data and word-address widths.
`define WB_DATA_W 32
`define WB_ADDR_W 2

// saturating disagreement counter width.
`define ERR_CNT_W 8

// register word addresses.
`define ADDR_CTRL   2'd0
`define ADDR_DATA   2'd1
`define ADDR_FAULT  2'd2
`define ADDR_STATUS 2'd3

`endif

/* common/tmr_pkg.sv */
`default_nettype none

`include "tmr_params.svh"

package tmr_pkg;

  // operating modes of the universal shift register.
  typedef enum logic [1:0] {
    SHIFT_RIGHT = 2'd0,
    SHIFT_LEFT  = 2'd1,
    PISO        = 2'd2,
    PIPO        = 2'd3
  } shift_mode_e;

  // control shared by all three replicas.
  // load and the fault masks are single-cycle pulses, the rest are levels.
  typedef struct packed {
    shift_mode_e           mode;
    logic                  load;
    logic [`TMR_WIDTH-1:0] load_data;
    logic                  scrub_en;
    logic [`TMR_WIDTH-1:0] fault_mask_0;
    logic [`TMR_WIDTH-1:0] fault_mask_1;
    logic [`TMR_WIDTH-1:0] fault_mask_2;
  } replica_ctrl_t;

  // result of the majority vote plus the error bookkeeping.
  typedef struct packed {
    logic [`TMR_WIDTH-1:0] voted_word;
    logic                  voted_serial;
    logic [2:0]            disagree;
    logic [`ERR_CNT_W-1:0] err_count;
  } vote_status_t;

endpackage

`default_nettype wire

/* common/wb_pkg.sv */
`default_nettype none

`include "tmr_params.svh"

package wb_pkg;

  // master to slave signals of a classic single transfer.
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master signals.
  typedef struct packed {
    logic                  ack;
    logic [`WB_DATA_W-1:0] dat;
  } wb_rsp_t;

  // register map of the slave.
  typedef enum logic [`WB_ADDR_W-1:0] {
    REG_CTRL   = `ADDR_CTRL,
    REG_DATA   = `ADDR_DATA,
    REG_FAULT  = `ADDR_FAULT,
    REG_STATUS = `ADDR_STATUS
  } reg_addr_e;

  // field positions inside the register words.
  localparam int CTRL_MODE_LSB   = 0;
  localparam int CTRL_SCRUB_BIT  = 2;
  localparam int FAULT_SEL_LSB   = 8;
  localparam int STATUS_CNT_LSB  = 8;

endpackage

`default_nettype wire

/* hdl/wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module wb_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  wb_pkg::wb_req_t        wb_req,
  output wb_pkg::wb_rsp_t        wb_rsp,
  input  tmr_pkg::vote_status_t  status,
  output tmr_pkg::replica_ctrl_t ctrl,
  output logic                   err_clear
);

  logic                  ack;
  logic                  accept;
  logic                  wr_en;
  wb_pkg::reg_addr_e     addr;
  logic [`WB_DATA_W-1:0] rdata;
  logic [`WB_DATA_W-1:0] rdata_q;

  tmr_pkg::shift_mode_e  mode;
  logic                  scrub_en;
  logic                  load;
  logic [`TMR_WIDTH-1:0] load_data;
  logic [`TMR_WIDTH-1:0] fault_mask_0;
  logic [`TMR_WIDTH-1:0] fault_mask_1;
  logic [`TMR_WIDTH-1:0] fault_mask_2;
  logic [1:0]            fault_sel;

  // a transfer is taken on the first edge that sees cyc and stb while ack is low.
  assign accept    = wb_req.cyc && wb_req.stb && !ack;
  assign wr_en     = accept && wb_req.we;
  assign addr      = wb_pkg::reg_addr_e'(wb_req.adr);
  assign fault_sel = wb_req.dat[wb_pkg::FAULT_SEL_LSB +: 2];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ack          <= 1'b0;
      mode         <= tmr_pkg::PIPO;
      scrub_en     <= 1'b0;
      load         <= 1'b0;
      fault_mask_0 <= '0;
      fault_mask_1 <= '0;
      fault_mask_2 <= '0;
      err_clear    <= 1'b0;
    end else begin
      ack          <= accept;
      load         <= 1'b0;
      fault_mask_0 <= '0;
      fault_mask_1 <= '0;
      fault_mask_2 <= '0;
      err_clear    <= 1'b0;
      if (wr_en) begin
        case (addr)
          wb_pkg::REG_CTRL: begin
            mode     <= tmr_pkg::shift_mode_e'(wb_req.dat[wb_pkg::CTRL_MODE_LSB +: 2]);
            scrub_en <= wb_req.dat[wb_pkg::CTRL_SCRUB_BIT];
          end
          wb_pkg::REG_DATA: begin
            load <= 1'b1;
          end
          wb_pkg::REG_FAULT: begin
            // selector value 3 addresses no replica and is ignored.
            case (fault_sel)
              2'd0:    fault_mask_0 <= wb_req.dat[`TMR_WIDTH-1:0];
              2'd1:    fault_mask_1 <= wb_req.dat[`TMR_WIDTH-1:0];
              2'd2:    fault_mask_2 <= wb_req.dat[`TMR_WIDTH-1:0];
              default: ;
            endcase
          end
          wb_pkg::REG_STATUS: begin
            err_clear <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // the load word rides along with the load pulse.
  always_ff @(posedge clk) begin
    if (wr_en && addr == wb_pkg::REG_DATA) begin
      load_data <= wb_req.dat[`TMR_WIDTH-1:0];
    end
  end

  always_comb begin
    rdata = '0;
    case (addr)
      wb_pkg::REG_CTRL: begin
        rdata[wb_pkg::CTRL_MODE_LSB +: 2] = mode;
        rdata[wb_pkg::CTRL_SCRUB_BIT]     = scrub_en;
      end
      wb_pkg::REG_DATA: begin
        rdata[`TMR_WIDTH-1:0] = status.voted_word;
      end
      wb_pkg::REG_STATUS: begin
        rdata[2:0]                                   = status.disagree;
        rdata[wb_pkg::STATUS_CNT_LSB +: `ERR_CNT_W] = status.err_count;
      end
      default: ;
    endcase
  end

  // read data is captured with the accept so it is stable while ack is high.
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= rdata;
    end
  end

  assign wb_rsp.ack = ack;
  assign wb_rsp.dat = rdata_q;

  assign ctrl.mode         = mode;
  assign ctrl.load         = load;
  assign ctrl.load_data    = load_data;
  assign ctrl.scrub_en     = scrub_en;
  assign ctrl.fault_mask_0 = fault_mask_0;
  assign ctrl.fault_mask_1 = fault_mask_1;
  assign ctrl.fault_mask_2 = fault_mask_2;

endmodule

`default_nettype wire

/* tmr/shift_replica.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module shift_replica (
  input  logic                   clk,
  input  logic                   rst,
  input  tmr_pkg::replica_ctrl_t ctrl,
  input  logic [`TMR_WIDTH-1:0]  fault_mask,
  input  logic [`TMR_WIDTH-1:0]  voted_word,
  input  logic                   shift_en,
  input  logic                   serial_in,
  output logic [`TMR_WIDTH-1:0]  state
);

  logic [`TMR_WIDTH-1:0] state_q;
  logic [`TMR_WIDTH-1:0] src;
  logic [`TMR_WIDTH-1:0] shifted;
  logic [`TMR_WIDTH-1:0] op_word;
  logic [`TMR_WIDTH-1:0] base_word;
  logic [`TMR_WIDTH-1:0] next_state;

  // with scrubbing the replica steps from the voted word, so a lone upset
  // is overwritten on the next edge.
  assign src = ctrl.scrub_en ? voted_word : state_q;

  always_comb begin
    case (ctrl.mode)
      tmr_pkg::SHIFT_RIGHT: shifted = {serial_in, src[`TMR_WIDTH-1:1]};
      tmr_pkg::SHIFT_LEFT:  shifted = {src[`TMR_WIDTH-2:0], serial_in};
      tmr_pkg::PISO:        shifted = {1'b0, src[`TMR_WIDTH-1:1]};
      tmr_pkg::PIPO:        shifted = src;
      default:              shifted = src;
    endcase
  end

  assign op_word   = shift_en ? shifted : src;
  assign base_word = ctrl.load ? ctrl.load_data : op_word;

  // the upset mask is xored in after load and shift.
  assign next_state = base_word ^ fault_mask;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= '0;
    end else begin
      state_q <= next_state;
    end
  end

  assign state = state_q;

endmodule

`default_nettype wire

/* tmr/tmr_voter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_voter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`TMR_WIDTH-1:0] state_0,
  input  logic [`TMR_WIDTH-1:0] state_1,
  input  logic [`TMR_WIDTH-1:0] state_2,
  input  tmr_pkg::shift_mode_e  mode,
  input  logic                  err_clear,
  output tmr_pkg::vote_status_t status
);

  logic [`TMR_WIDTH-1:0] voted_word;
  logic                  voted_serial;
  logic [2:0]            disagree;
  logic [`ERR_CNT_W-1:0] err_count;

  assign voted_word = (state_0 & state_1) | (state_0 & state_2) | (state_1 & state_2);

  // each bit of the voted word is already the majority of that bit over all
  // three replicas, so the serial pick inherits the full vote.
  assign voted_serial = (mode == tmr_pkg::SHIFT_RIGHT || mode == tmr_pkg::PISO)
                        ? voted_word[0] : voted_word[`TMR_WIDTH-1];

  assign disagree[0] = |(state_0 ^ voted_word);
  assign disagree[1] = |(state_1 ^ voted_word);
  assign disagree[2] = |(state_2 ^ voted_word);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      err_count <= '0;
    end else if (err_clear) begin
      err_count <= '0;
    end else if (|disagree && err_count != '1) begin
      err_count <= err_count + 1'b1;
    end
  end

  assign status.voted_word   = voted_word;
  assign status.voted_serial = voted_serial;
  assign status.disagree     = disagree;
  assign status.err_count    = err_count;

endmodule

`default_nettype wire

/* hdl/tmr_shift_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_shift_top (
  input  logic                  clk,
  input  logic                  rst,
  input  wb_pkg::wb_req_t       wb_req,
  output wb_pkg::wb_rsp_t       wb_rsp,
  input  logic                  shift_en,
  input  logic                  serial_in,
  output logic                  serial_out,
  output logic [`TMR_WIDTH-1:0] parallel_out,
  output logic                  err_flag
);

  tmr_pkg::replica_ctrl_t ctrl;
  tmr_pkg::vote_status_t  status;
  logic                   err_clear;
  logic [`TMR_WIDTH-1:0]  state_0;
  logic [`TMR_WIDTH-1:0]  state_1;
  logic [`TMR_WIDTH-1:0]  state_2;

  wb_regs u_wb_regs (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .status    (status),
    .ctrl      (ctrl),
    .err_clear (err_clear)
  );

  shift_replica replica_0 (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .fault_mask (ctrl.fault_mask_0),
    .voted_word (status.voted_word),
    .shift_en   (shift_en),
    .serial_in  (serial_in),
    .state      (state_0)
  );

  shift_replica replica_1 (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .fault_mask (ctrl.fault_mask_1),
    .voted_word (status.voted_word),
    .shift_en   (shift_en),
    .serial_in  (serial_in),
    .state      (state_1)
  );

  shift_replica replica_2 (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .fault_mask (ctrl.fault_mask_2),
    .voted_word (status.voted_word),
    .shift_en   (shift_en),
    .serial_in  (serial_in),
    .state      (state_2)
  );

  tmr_voter u_tmr_voter (
    .clk       (clk),
    .rst       (rst),
    .state_0   (state_0),
    .state_1   (state_1),
    .state_2   (state_2),
    .mode      (ctrl.mode),
    .err_clear (err_clear),
    .status    (status)
  );

  assign serial_out   = status.voted_serial;
  assign parallel_out = status.voted_word;
  assign err_flag     = |status.disagree;

endmodule

`default_nettype wire

/* tests/tmr_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tmr_assert (
  input logic                  clk,
  input logic                  rst,
  input logic                  cyc,
  input logic                  stb,
  input logic                  ack,
  input logic [`TMR_WIDTH-1:0] state_0,
  input logic [`TMR_WIDTH-1:0] state_1,
  input logic [`TMR_WIDTH-1:0] state_2,
  input logic [2:0]            disagree,
  input logic [`ERR_CNT_W-1:0] err_count,
  input logic                  err_clear
);

  int fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
    else begin
      $error("ack stayed high for more than one cycle");
      fail_count++;
    end

  // every ack answers a request that was present on the edge before.
  ack_after_request: assert property (@(posedge clk) disable iff (!rst)
    ack |-> $past(cyc && stb))
    else begin
      $error("ack without a preceding cyc and stb");
      fail_count++;
    end

  single_differ: assert property (@(posedge clk) disable iff (!rst)
    ((state_0 != state_1 && state_1 == state_2) |-> disagree == 3'b001) and
    ((state_1 != state_0 && state_0 == state_2) |-> disagree == 3'b010) and
    ((state_2 != state_0 && state_0 == state_1) |-> disagree == 3'b100))
    else begin
      $error("disagree does not mark the single differing replica");
      fail_count++;
    end

  count_monotonic: assert property (@(posedge clk) disable iff (!rst)
    !$past(err_clear) |-> err_count >= $past(err_count))
    else begin
      $error("err_count decreased without a clear");
      fail_count++;
    end

endmodule

`default_nettype wire

/* tests/tb_tmr_shift.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tmr_params.svh"

module tb_tmr_shift;

  localparam int W = `TMR_WIDTH;
  localparam int ACK_TIMEOUT = 16;

  logic                  clk;
  logic                  rst;
  wb_pkg::wb_req_t       wb_req;
  wb_pkg::wb_rsp_t       wb_rsp;
  logic                  shift_en;
  logic                  serial_in;
  logic                  serial_out;
  logic [W-1:0]          parallel_out;
  logic                  err_flag;

  // reference model of the slave registers, the replicas and the counter.
  logic [W-1:0]          m_rep [3];
  logic [W-1:0]          m_mask [3];
  tmr_pkg::shift_mode_e  m_mode;
  logic                  m_scrub;
  logic                  m_load;
  logic [W-1:0]          m_load_data;
  logic                  m_clear;
  logic                  m_ack;
  logic [`WB_DATA_W-1:0] m_rdata;
  logic [`ERR_CNT_W-1:0] m_count;
  int                    checks;
  int                    errors;

  tmr_shift_top DUT (
    .clk          (clk),
    .rst          (rst),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .shift_en     (shift_en),
    .serial_in    (serial_in),
    .serial_out   (serial_out),
    .parallel_out (parallel_out),
    .err_flag     (err_flag)
  );

  bind tmr_shift_top tmr_assert u_tmr_assert (
    .clk       (clk),
    .rst       (rst),
    .cyc       (wb_req.cyc),
    .stb       (wb_req.stb),
    .ack       (wb_rsp.ack),
    .state_0   (state_0),
    .state_1   (state_1),
    .state_2   (state_2),
    .disagree  (status.disagree),
    .err_count (status.err_count),
    .err_clear (err_clear)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [W-1:0] vote3(input logic [W-1:0] a, input logic [W-1:0] b,
                                         input logic [W-1:0] c);
    logic [W-1:0] v;
    for (int i = 0; i < W; i++) begin
      v[i] = (int'(a[i]) + int'(b[i]) + int'(c[i])) >= 2;
    end
    return v;
  endfunction

  function automatic logic [2:0] disagree_of(input logic [W-1:0] voted);
    return {m_rep[2] != voted, m_rep[1] != voted, m_rep[0] != voted};
  endfunction

  function automatic logic serial_pick(input logic [W-1:0] voted,
                                       input tmr_pkg::shift_mode_e mode);
    if (mode == tmr_pkg::SHIFT_RIGHT || mode == tmr_pkg::PISO) begin
      return voted[0];
    end
    return voted[W-1];
  endfunction

  // the next word of one replica comes from a load, else a shift or hold,
  // and the upset mask goes on top.
  function automatic logic [W-1:0] model_step(input logic [W-1:0] own,
      input logic [W-1:0] voted, input tmr_pkg::shift_mode_e mode, input logic scrub,
      input logic sh, input logic si, input logic ld, input logic [W-1:0] ld_data,
      input logic [W-1:0] mask);
    logic [W-1:0] src;
    logic [W-1:0] res;
    src = scrub ? voted : own;
    res = src;
    if (ld) begin
      res = ld_data;
    end else if (sh) begin
      case (mode)
        tmr_pkg::SHIFT_RIGHT: res = {si, src[W-1:1]};
        tmr_pkg::SHIFT_LEFT:  res = {src[W-2:0], si};
        tmr_pkg::PISO:        res = {1'b0, src[W-1:1]};
        default:              res = src;
      endcase
    end
    return res ^ mask;
  endfunction

  always @(posedge clk or negedge rst) begin : ref_model
    logic [W-1:0] voted;
    logic [W-1:0] nxt [3];
    logic [2:0]   dis;
    logic         accept;
    if (!rst) begin
      for (int i = 0; i < 3; i++) begin
        m_rep[i]  = '0;
        m_mask[i] = '0;
      end
      m_mode      = tmr_pkg::PIPO;
      m_scrub     = 1'b0;
      m_load      = 1'b0;
      m_load_data = '0;
      m_clear     = 1'b0;
      m_ack       = 1'b0;
      m_rdata     = '0;
      m_count     = '0;
    end else begin
      voted  = vote3(m_rep[0], m_rep[1], m_rep[2]);
      dis    = disagree_of(voted);
      accept = wb_req.cyc && wb_req.stb && !m_ack;
      if (accept) begin
        m_rdata = '0;
        case (wb_req.adr)
          wb_pkg::REG_CTRL:   m_rdata[2:0] = {m_scrub, m_mode};
          wb_pkg::REG_DATA:   m_rdata[W-1:0] = voted;
          wb_pkg::REG_STATUS: m_rdata[15:0] = {m_count, 5'b0, dis};
          default: ;
        endcase
      end
      for (int i = 0; i < 3; i++) begin
        nxt[i] = model_step(m_rep[i], voted, m_mode, m_scrub, shift_en, serial_in,
                            m_load, m_load_data, m_mask[i]);
      end
      if (m_clear) begin
        m_count = '0;
      end else if (dis != 3'b000 && m_count != '1) begin
        m_count = m_count + 1'b1;
      end
      for (int i = 0; i < 3; i++) begin
        m_rep[i]  = nxt[i];
        m_mask[i] = '0;
      end
      m_load  = 1'b0;
      m_clear = 1'b0;
      m_ack   = accept;
      if (accept && wb_req.we) begin
        case (wb_req.adr)
          wb_pkg::REG_CTRL: begin
            m_mode  = tmr_pkg::shift_mode_e'(wb_req.dat[1:0]);
            m_scrub = wb_req.dat[2];
          end
          wb_pkg::REG_DATA: begin
            m_load      = 1'b1;
            m_load_data = wb_req.dat[W-1:0];
          end
          wb_pkg::REG_FAULT: begin
            if (wb_req.dat[9:8] != 2'd3) begin
              m_mask[wb_req.dat[9:8]] = wb_req.dat[W-1:0];
            end
          end
          default: m_clear = 1'b1;
        endcase
      end
    end
  end

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin : compare_outputs
    logic [W-1:0] exp_word;
    #2;
    if (rst) begin
      exp_word = vote3(m_rep[0], m_rep[1], m_rep[2]);
      expect_value("parallel_out", parallel_out, exp_word);
      expect_value("serial_out", serial_out, serial_pick(exp_word, m_mode));
      expect_value("err_flag", err_flag, |disagree_of(exp_word));
      expect_value("wb_rsp.ack", wb_rsp.ack, m_ack);
    end
  end

  task automatic wait_ack(input logic [`WB_ADDR_W-1:0] adr);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!wb_rsp.ack) begin
      $display("Timeout: the slave gave no ack for address %0d", adr);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  task automatic bus_write(input logic [`WB_ADDR_W-1:0] adr, input logic [31:0] dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wait_ack(adr);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic bus_read(input logic [`WB_ADDR_W-1:0] adr, output logic [31:0] dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wait_ack(adr);
    expect_value("wb_rsp.dat", wb_rsp.dat, m_rdata);
    dat        = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic run_random(input int n);
    repeat (n) begin
      @(negedge clk);
      shift_en  = 1'($urandom);
      serial_in = 1'($urandom);
    end
    @(negedge clk);
    shift_en = 1'b0;
  endtask

  task automatic end_test(input string name, input int base);
    if (errors == base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - base);
    end
  endtask

  initial begin : main
    logic [W-1:0] word;
    logic [W-1:0] mask;
    logic [1:0]   sel;
    logic [31:0]  rd;
    int           base;
    int           total;
    rd        = $urandom(32'h077e_0c10);
    rst       = 1'b0;
    wb_req    = '0;
    shift_en  = 1'b0;
    serial_in = 1'b0;
    checks    = 0;
    errors    = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    base = errors;
    bus_read(wb_pkg::REG_CTRL, rd);
    expect_value("ctrl after reset", rd, 32'(tmr_pkg::PIPO));
    bus_read(wb_pkg::REG_STATUS, rd);
    expect_value("status after reset", rd, 32'h0);
    bus_write(wb_pkg::REG_CTRL, 32'h4 | 32'(tmr_pkg::SHIFT_LEFT));
    bus_read(wb_pkg::REG_CTRL, rd);
    expect_value("ctrl readback", rd, 32'h4 | 32'(tmr_pkg::SHIFT_LEFT));
    end_test("reset and register access", base);

    base = errors;
    for (int m = 0; m < 4; m++) begin
      bus_write(wb_pkg::REG_CTRL, 32'(m));
      word = W'($urandom);
      bus_write(wb_pkg::REG_DATA, 32'(word));
      run_random(40);
    end
    end_test("shift modes", base);

    base = errors;
    bus_write(wb_pkg::REG_CTRL, 32'(tmr_pkg::PIPO));
    repeat (4) begin
      word = W'($urandom);
      mask = W'(1 + ($urandom % 255));
      sel  = 2'($urandom % 3);
      bus_write(wb_pkg::REG_DATA, 32'(word));
      bus_write(wb_pkg::REG_FAULT, {22'b0, sel, mask});
      run_random(6);
      bus_read(wb_pkg::REG_STATUS, rd);
      expect_value("disagree", rd[2:0], 32'(3'b001 << sel));
      expect_value("parallel_out under fault", parallel_out, word);
    end
    end_test("fault masking", base);

    base = errors;
    bus_write(wb_pkg::REG_CTRL, 32'h4 | 32'(tmr_pkg::PIPO));
    repeat (3) begin
      mask = W'(1 + ($urandom % 255));
      sel  = 2'($urandom % 3);
      bus_write(wb_pkg::REG_STATUS, 32'h0);
      bus_write(wb_pkg::REG_FAULT, {22'b0, sel, mask});
      run_random(4);
      bus_read(wb_pkg::REG_STATUS, rd);
      expect_value("disagree after scrub", rd[2:0], 32'h0);
      expect_value("err_count after scrub", rd[15:8], 32'h1);
    end
    end_test("scrub repair", base);

    base = errors;
    bus_write(wb_pkg::REG_CTRL, 32'(tmr_pkg::PIPO));
    word = W'($urandom);
    mask = W'(1 + ($urandom % 255));
    bus_write(wb_pkg::REG_DATA, 32'(word));
    bus_write(wb_pkg::REG_FAULT, {22'b0, 2'd0, mask});
    run_random(270);
    bus_read(wb_pkg::REG_STATUS, rd);
    expect_value("saturated err_count", rd[15:8], 32'hff);
    bus_write(wb_pkg::REG_DATA, 32'(word));
    bus_write(wb_pkg::REG_STATUS, 32'h0);
    bus_read(wb_pkg::REG_STATUS, rd);
    expect_value("cleared status", rd, 32'h0);
    // two replicas upset on the same bits outvote the third one.
    bus_write(wb_pkg::REG_FAULT, {22'b0, 2'd0, mask});
    bus_write(wb_pkg::REG_FAULT, {22'b0, 2'd1, mask});
    @(negedge clk);
    expect_value("parallel_out after double fault", parallel_out, word ^ mask);
    bus_read(wb_pkg::REG_STATUS, rd);
    expect_value("disagree after double fault", rd[2:0], 32'h4);
    end_test("counter and double fault", base);

    total = errors + DUT.u_tmr_assert.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             DUT.u_tmr_assert.fail_count);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+common
common/tmr_pkg.sv
common/wb_pkg.sv
hdl/wb_regs.sv
tmr/shift_replica.sv
tmr/tmr_voter.sv
hdl/tmr_shift_top.sv
tests/tmr_assert.sv
tests/tb_tmr_shift.sv
